//--- vlog.f
mmuPkg.sv
fetchAlignCheck.sv
instTlb.sv
instMmu.sv
translateResult.sv
itlbTop.sv
tb_itlbTop.sv

//--- Makefile
# Verilator build and run of the instruction translation testbench

TOP := tb_itlbTop

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		-f vlog.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx 'all tests passed'

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps \
		-f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- tb_itlbTop.sv
// Testbench for the instruction address translation path
// Shadow TLB, queue of expected results and concurrent checks
// on every result and on the fixed two-edge latency

`timescale 1ns/10ps

module tb_itlbTop;

    import mmuPkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int TLB_N           = 16;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RANDOM_CYCLES   = 600;
    localparam int MARGIN_CYCLES   = 100;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES +
                                     RANDOM_CYCLES + MARGIN_CYCLES;

    integer seed = 32'h2e5deaa6;

    logic              clk;
    logic              rst;
    logic              fetchReq;
    logic [31:0]       vAddr;
    logic [ASID_W-1:0] asid;
    logic [2:0]        k0Field;
    logic              tlbWe;
    logic [3:0]        tlbWIndex;
    logic [VPN2_W-1:0] tlbVpn2;
    logic [ASID_W-1:0] tlbAsid;
    logic              tlbG;
    logic [PFN_W-1:0]  tlbPfn0;
    logic [2:0]        tlbC0;
    logic              tlbD0;
    logic              tlbV0;
    logic [PFN_W-1:0]  tlbPfn1;
    logic [2:0]        tlbC1;
    logic              tlbD1;
    logic              tlbV1;
    logic              resValid;
    logic [31:0]       pAddr;
    logic              unCache;
    logic              excValid;
    logic [4:0]        excCode;
    logic              isRefill;

    // Shadow TLB
    logic [TLB_N-1:0]  sLive;
    logic [TLB_N-1:0]  sG;
    logic [TLB_N-1:0]  sV0;
    logic [TLB_N-1:0]  sV1;
    logic [VPN2_W-1:0] sVpn2 [TLB_N];
    logic [ASID_W-1:0] sAsid [TLB_N];
    logic [PFN_W-1:0]  sPfn0 [TLB_N];
    logic [PFN_W-1:0]  sPfn1 [TLB_N];
    logic [2:0]        sC0   [TLB_N];
    logic [2:0]        sC1   [TLB_N];

    // Expected result {pending, exc, code, refill, uncached, pAddr}
    logic [40:0] expQ [$];
    logic [40:0] expHead;
    int resultErrors;
    int latencyErrors;
    int lostResults;

    itlbTop #(.TLB_ENTRIES(TLB_N)) u_itlbTop (
        .clk(clk), .rst(rst),
        .fetchReq_i(fetchReq), .vAddr_i(vAddr), .asid_i(asid), .k0Field_i(k0Field),
        .tlbWe_i(tlbWe), .tlbWIndex_i(tlbWIndex),
        .tlbVpn2_i(tlbVpn2), .tlbAsid_i(tlbAsid), .tlbG_i(tlbG),
        .tlbPfn0_i(tlbPfn0), .tlbC0_i(tlbC0), .tlbD0_i(tlbD0), .tlbV0_i(tlbV0),
        .tlbPfn1_i(tlbPfn1), .tlbC1_i(tlbC1), .tlbD1_i(tlbD1), .tlbV1_i(tlbV1),
        .resValid_o(resValid), .pAddr_o(pAddr), .unCache_o(unCache),
        .excValid_o(excValid), .excCode_o(excCode), .isRefill_o(isRefill)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [40:0] expectFetch(input logic [31:0] addr,
                                                input logic [ASID_W-1:0] asidIn,
                                                input logic [2:0] k0In);
        vAddrU            va;
        logic             hit;
        logic [PFN_W-1:0] pfn;
        logic [2:0]       c;
        logic             v;
        va  = addr;
        hit = 1'b0;
        pfn = '0;
        c   = '0;
        v   = 1'b0;
        // Alignment beats every other fault
        if (addr[1:0] != 2'b00) return {2'b11, EXC_ADEL, 2'b00, 32'h0};
        if (va.segView.seg == SEG_KSEG1) begin
            return {2'b10, 5'd0, 2'b01, 3'b000, va.segView.segOffset};
        end
        if (va.segView.seg == SEG_KSEG0) begin
            return {2'b10, 5'd0, 1'b0, k0In != CACHE_CACHED, 3'b000, va.segView.segOffset};
        end
        for (int i = 0; i < TLB_N; i++) begin
            if (sLive[i] && sVpn2[i] == va.tlbView.vpn2 && (sG[i] || sAsid[i] == asidIn)) begin
                hit = 1'b1;
                pfn = va.tlbView.oddPage ? sPfn1[i] : sPfn0[i];
                c   = va.tlbView.oddPage ? sC1[i] : sC0[i];
                v   = va.tlbView.oddPage ? sV1[i] : sV0[i];
            end
        end
        // Miss is a refill, invalid page is not
        if (!hit) return {2'b11, EXC_TLBL, 2'b10, 32'h0};
        if (!v) return {2'b11, EXC_TLBL, 2'b00, 32'h0};
        return {2'b10, 5'd0, 1'b0, c != CACHE_CACHED, pfn, va.tlbView.pageOff};
    endfunction

    // Mapped page pair, low nibble tied to the slot so entries never overlap
    function automatic logic [VPN2_W-1:0] mappedVpn2(input logic [3:0] idx,
                                                     input logic [31:0] bits);
        logic [2:0] seg;
        seg = bits[2:0];
        if (seg[2:1] == 2'b10) seg[2] = 1'b0;
        return {seg, bits[14:3], idx};
    endfunction

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic issueFetch(input logic [31:0] addr, input logic [ASID_W-1:0] asidIn,
                              input logic [2:0] k0In);
        @(posedge clk);
        expQ.push_back(expectFetch(addr, asidIn, k0In));
        fetchReq <= 1'b1;
        vAddr    <= addr;
        asid     <= asidIn;
        k0Field  <= k0In;
        tlbWe    <= 1'b0;
    endtask

    task automatic writeEntry(input logic [3:0] idx, input logic [VPN2_W-1:0] vpn2,
                              input logic [ASID_W-1:0] asidIn, input logic g,
                              input logic [PFN_W-1:0] pfn0, input logic [2:0] c0,
                              input logic v0, input logic [PFN_W-1:0] pfn1,
                              input logic [2:0] c1, input logic v1);
        logic [31:0] r;
        r = $random(seed);
        @(posedge clk);
        fetchReq  <= 1'b0;
        tlbWe     <= 1'b1;
        tlbWIndex <= idx;
        tlbVpn2   <= vpn2;
        tlbAsid   <= asidIn;
        tlbG      <= g;
        tlbPfn0   <= pfn0;
        tlbC0     <= c0;
        tlbD0     <= r[0];
        tlbV0     <= v0;
        tlbPfn1   <= pfn1;
        tlbC1     <= c1;
        tlbD1     <= r[1];
        tlbV1     <= v1;
        sLive[idx] = 1'b1;
        sVpn2[idx] = vpn2;
        sAsid[idx] = asidIn;
        sG[idx]    = g;
        sPfn0[idx] = pfn0;
        sC0[idx]   = c0;
        sV0[idx]   = v0;
        sPfn1[idx] = pfn1;
        sC1[idx]   = c1;
        sV1[idx]   = v1;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        fetchReq <= 1'b0;
        tlbWe    <= 1'b0;
    endtask

    task automatic randomFetch();
        logic [31:0] r;
        logic [31:0] bits;
        logic [31:0] addr;
        r    = $random(seed);
        bits = $random(seed);
        case (r[1:0])
            2'd0:    addr = {SEG_KSEG0, bits[28:0]};
            2'd1:    addr = {SEG_KSEG1, bits[28:0]};
            // Likely hit on whatever sits in the slot
            2'd2:    addr = {sVpn2[r[5:2]], bits[12:0]};
            default: addr = {mappedVpn2(r[5:2], bits), bits[27:15]};
        endcase
        // Mostly aligned
        addr[1:0] = (r[8:6] == 3'd0) ? r[10:9] : 2'b00;
        issueFetch(addr, r[11] ? 8'h11 : 8'h22, r[12] ? CACHE_CACHED : r[15:13]);
    endtask

    task automatic randomWrite();
        logic [31:0] r;
        logic [31:0] bits;
        logic [31:0] p;
        r    = $random(seed);
        bits = $random(seed);
        p    = $random(seed);
        writeEntry(r[3:0], mappedVpn2(r[3:0], bits), r[5] ? 8'h11 : 8'h22, r[4],
                   p[19:0], r[8:6], r[13:12] != 2'b00,
                   {p[31:20], r[31:24]}, r[11:9], r[15:14] != 2'b00);
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Head of the queue for the result due at the next edge
    always @(posedge clk) begin
        if (rst && resValid && expQ.size() > 0) void'(expQ.pop_front());
        expHead <= (expQ.size() > 0) ? expQ[0] : '0;
    end

    checkResult: assert property (
        @(posedge clk) disable iff (!rst)
        resValid |-> expHead[40] && excValid == expHead[39] && isRefill == expHead[33] &&
            (!expHead[39] || excCode == expHead[38:34]) &&
            (expHead[39] || (pAddr == expHead[31:0] && unCache == expHead[32]))
    ) else begin
        resultErrors++;
        $display("ERROR %0t: got exc=%b code=%0d refill=%b unc=%b pa=%h, expected %h",
                 $time, excValid, excCode, isRefill, unCache, pAddr, expHead);
    end

    // Fixed two-edge latency, no result without a request
    checkLatency: assert property (
        @(posedge clk) disable iff (!rst)
        resValid == $past(fetchReq, 2)
    ) else begin
        latencyErrors++;
        $display("ERROR %0t: resValid_o=%b but fetch two edges earlier was %b",
                 $time, resValid, !resValid);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run still busy after %0d clock cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        rst           = 1'b0;
        fetchReq      = 1'b0;
        vAddr         = '0;
        asid          = '0;
        k0Field       = CACHE_CACHED;
        tlbWe         = 1'b0;
        tlbWIndex     = '0;
        tlbVpn2       = '0;
        tlbAsid       = '0;
        tlbG          = 1'b0;
        tlbPfn0       = '0;
        tlbC0         = '0;
        tlbD0         = 1'b0;
        tlbV0         = 1'b0;
        tlbPfn1       = '0;
        tlbC1         = '0;
        tlbD1         = 1'b0;
        tlbV1         = 1'b0;
        resultErrors  = 0;
        latencyErrors = 0;
        lostResults   = 0;
        expHead       = '0;
        sLive         = '0;
        sG            = '0;
        sV0           = '0;
        sV1           = '0;
        for (int i = 0; i < TLB_N; i++) begin
            sVpn2[i] = '0;
            sAsid[i] = '0;
            sPfn0[i] = '0;
            sPfn1[i] = '0;
            sC0[i]   = '0;
            sC1[i]   = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;

        // Empty TLB misses, then direct segments
        issueFetch({19'h00010, 1'b0, 12'h100}, 8'h11, 3'd3);
        issueFetch(32'hA000_1230, 8'h11, 3'd3);
        issueFetch(32'hBFFF_FFFC, 8'h11, 3'd2);
        issueFetch(32'h8000_0040, 8'h11, 3'd3);
        issueFetch(32'h9234_5678, 8'h11, 3'd2);

        // Global, ASID-matched, half-invalid and kseg3 entries
        writeEntry(4'd0, 19'h00010, 8'h00, 1'b1, 20'h12345, 3'd3, 1'b1, 20'h23456, 3'd2, 1'b1);
        writeEntry(4'd1, 19'h01231, 8'h11, 1'b0, 20'h34567, 3'd2, 1'b1, 20'h45678, 3'd3, 1'b1);
        writeEntry(4'd2, 19'h64562, 8'h11, 1'b1, 20'h56789, 3'd3, 1'b1, 20'h6789a, 3'd3, 1'b0);
        writeEntry(4'd3, 19'h7abc3, 8'h22, 1'b0, 20'h789ab, 3'd0, 1'b0, 20'h89abc, 3'd5, 1'b1);
        issueFetch({19'h00010, 1'b0, 12'h104}, 8'h11, 3'd3);
        issueFetch({19'h00010, 1'b1, 12'hffc}, 8'h22, 3'd3);
        issueFetch({19'h01231, 1'b0, 12'h010}, 8'h11, 3'd3);
        issueFetch({19'h01231, 1'b1, 12'h020}, 8'h11, 3'd3);
        issueFetch({19'h01231, 1'b0, 12'h010}, 8'h22, 3'd3);
        issueFetch({19'h64562, 1'b0, 12'h400}, 8'h22, 3'd3);
        issueFetch({19'h64562, 1'b1, 12'h400}, 8'h22, 3'd3);
        issueFetch({19'h7abc3, 1'b1, 12'h008}, 8'h22, 3'd3);

        // Misaligned PCs in each segment, one on a TLB miss
        issueFetch(32'h8000_0041, 8'h11, 3'd3);
        issueFetch(32'hA000_0002, 8'h11, 3'd3);
        issueFetch({19'h00010, 1'b0, 12'h103}, 8'h11, 3'd3);
        issueFetch({19'h05555, 1'b1, 12'h001}, 8'h11, 3'd3);

        // Back-to-back stream, writes in the gaps
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            if ($random(seed) % 8 == 0) randomWrite();
            else randomFetch();
        end

        // Pipeline drains in two edges
        repeat (4) idleCycle();
        if (expQ.size() != 0) begin
            lostResults = expQ.size();
            $display("%0d expected results never came back from the DUT", lostResults);
        end
        $display("Errors: result %0d, latency %0d, lost %0d",
                 resultErrors, latencyErrors, lostResults);
        if (resultErrors + latencyErrors + lostResults == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- itlbTop.sv
// Instruction-side address translation top level
// Two-cycle path from fetch PC to physical address, uncached flag
// and fetch exception, with a TLBWI-style TLB write port

`timescale 1ns/10ps

module itlbTop #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    // Fetch request
    input  logic                               fetchReq_i,
    input  logic [31:0]                        vAddr_i,
    input  logic [mmuPkg::ASID_W-1:0]          asid_i,
    input  logic [2:0]                         k0Field_i,
    // TLB write
    input  logic                               tlbWe_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0]     tlbWIndex_i,
    input  logic [mmuPkg::VPN2_W-1:0]          tlbVpn2_i,
    input  logic [mmuPkg::ASID_W-1:0]          tlbAsid_i,
    input  logic                               tlbG_i,
    input  logic [mmuPkg::PFN_W-1:0]           tlbPfn0_i,
    input  logic [2:0]                         tlbC0_i,
    input  logic                               tlbD0_i,
    input  logic                               tlbV0_i,
    input  logic [mmuPkg::PFN_W-1:0]           tlbPfn1_i,
    input  logic [2:0]                         tlbC1_i,
    input  logic                               tlbD1_i,
    input  logic                               tlbV1_i,
    // Result, two edges after the request
    output logic                               resValid_o,
    output logic [31:0]                        pAddr_o,
    output logic                               unCache_o,
    output logic                               excValid_o,
    output logic [4:0]                         excCode_o,
    output logic                               isRefill_o
);

    import mmuPkg::*;

    // Stage one
    logic              s1Valid;
    vAddrU             s1VAddr;
    logic              s1AdEL;
    // TLB lookup and answer
    logic              tlbReq;
    logic [VPN2_W-1:0] tlbVpn2;
    logic              tlbOdd;
    logic              tlbHit;
    logic [PFN_W-1:0]  tlbPfn;
    logic [2:0]        tlbC;
    logic              tlbV;
    // MMU combine
    logic [PFN_W-1:0]  mmuTag;
    logic              mmuUnCache;
    logic              mmuTlbExc;
    logic              mmuRefill;

    fetchAlignCheck u_fetchAlignCheck (
        .clk(clk), .rst(rst),
        .fetchReq_i(fetchReq_i), .vAddr_i(vAddr_i),
        .valid_o(s1Valid), .vAddr_o(s1VAddr), .adEL_o(s1AdEL)
    );

    instMmu u_instMmu (
        .clk(clk), .rst(rst),
        .fetchReq_i(fetchReq_i), .vAddr_i(vAddr_i), .k0Field_i(k0Field_i),
        .hit_i(tlbHit), .pfn_i(tlbPfn), .c_i(tlbC), .v_i(tlbV),
        .tlbReq_o(tlbReq), .tlbVpn2_o(tlbVpn2), .tlbOdd_o(tlbOdd),
        .tag_o(mmuTag), .unCache_o(mmuUnCache),
        .tlbExc_o(mmuTlbExc), .refill_o(mmuRefill)
    );

    // ASID comes straight from the core
    instTlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_instTlb (
        .clk(clk), .rst(rst),
        .lookReq_i(tlbReq), .lookVpn2_i(tlbVpn2),
        .lookOdd_i(tlbOdd), .lookAsid_i(asid_i),
        .tlbWe_i(tlbWe_i), .tlbWIndex_i(tlbWIndex_i),
        .tlbVpn2_i(tlbVpn2_i), .tlbAsid_i(tlbAsid_i), .tlbG_i(tlbG_i),
        .tlbPfn0_i(tlbPfn0_i), .tlbC0_i(tlbC0_i), .tlbD0_i(tlbD0_i), .tlbV0_i(tlbV0_i),
        .tlbPfn1_i(tlbPfn1_i), .tlbC1_i(tlbC1_i), .tlbD1_i(tlbD1_i), .tlbV1_i(tlbV1_i),
        .hit_o(tlbHit), .pfn_o(tlbPfn), .c_o(tlbC), .v_o(tlbV)
    );

    translateResult u_translateResult (
        .clk(clk), .rst(rst),
        .valid_i(s1Valid), .adEL_i(s1AdEL), .pageOff_i(s1VAddr.tlbView.pageOff),
        .tag_i(mmuTag), .unCache_i(mmuUnCache),
        .tlbExc_i(mmuTlbExc), .refill_i(mmuRefill),
        .resValid_o(resValid_o), .pAddr_o(pAddr_o), .unCache_o(unCache_o),
        .excValid_o(excValid_o), .excCode_o(excCode_o), .isRefill_o(isRefill_o)
    );

endmodule

//--- translateResult.sv
// Translation result stage
// Merges alignment and TLB faults with AdEL first, builds the
// physical address and registers every output

`timescale 1ns/10ps

module translateResult (
    input  logic                       clk,
    input  logic                       rst,
    // Stage one state
    input  logic                       valid_i,
    input  logic                       adEL_i,
    input  logic [11:0]                pageOff_i,
    // MMU answer
    input  logic [mmuPkg::PFN_W-1:0]   tag_i,
    input  logic                       unCache_i,
    input  logic                       tlbExc_i,
    input  logic                       refill_i,
    // Final result, cycle 2
    output logic                       resValid_o,
    output logic [31:0]                pAddr_o,
    output logic                       unCache_o,
    output logic                       excValid_o,
    output logic [4:0]                 excCode_o,
    output logic                       isRefill_o
);

    import mmuPkg::*;

    // ----------------------------------------
    // Control outputs
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            resValid_o <= 1'b0;
            excValid_o <= 1'b0;
            isRefill_o <= 1'b0;
        end else begin
            resValid_o <= valid_i;
            excValid_o <= valid_i && (adEL_i || tlbExc_i);
            // AdEL masks any refill
            isRefill_o <= valid_i && !adEL_i && refill_i;
        end
    end

    // Payload, held between results
    always_ff @(posedge clk) begin
        if (valid_i) begin
            pAddr_o   <= {tag_i, pageOff_i};
            unCache_o <= unCache_i;
            excCode_o <= adEL_i ? EXC_ADEL : EXC_TLBL;
        end
    end

    // Exception only rides on a result
    aExcHasResult: assert property (
        @(posedge clk) disable iff (!rst)
        excValid_o |-> resValid_o
    ) else $error("translateResult: excValid_o without resValid_o at %0t", $time);

endmodule

//--- instMmu.sv
// Instruction MMU segment logic
// Registers the kseg decode of a fetch, issues the TLB lookup for
// mapped segments and folds the TLB answer into tag, uncached flag
// and TLB exception

`timescale 1ns/10ps

module instMmu (
    input  logic                       clk,
    input  logic                       rst,
    // Fetch request, cycle 0
    input  logic                       fetchReq_i,
    input  mmuPkg::vAddrU              vAddr_i,
    // Config K0 field
    input  logic [2:0]                 k0Field_i,
    // TLB answer, cycle 1
    input  logic                       hit_i,
    input  logic [mmuPkg::PFN_W-1:0]   pfn_i,
    input  logic [2:0]                 c_i,
    input  logic                       v_i,
    // TLB lookup, cycle 0
    output logic                       tlbReq_o,
    output logic [mmuPkg::VPN2_W-1:0]  tlbVpn2_o,
    output logic                       tlbOdd_o,
    // Translation, cycle 1
    output logic [mmuPkg::PFN_W-1:0]   tag_o,
    output logic                       unCache_o,
    output logic                       tlbExc_o,
    output logic                       refill_o
);

    import mmuPkg::*;

    logic             inKseg0;
    logic             inKseg1;
    logic             inMapped;
    // Registered segment state
    logic             isKseg0;
    logic             isKseg1;
    logic             isMapped;
    logic             kseg0UnCache;
    logic [PFN_W-1:0] directTag;

    // ----------------------------------------
    // Cycle 0 decode
    // ----------------------------------------
    assign inKseg0  = vAddr_i.segView.seg == SEG_KSEG0;
    assign inKseg1  = vAddr_i.segView.seg == SEG_KSEG1;
    // kuseg and kseg2/3
    assign inMapped = !inKseg0 && !inKseg1;

    // Lookup only for mapped fetches
    assign tlbReq_o  = fetchReq_i && inMapped;
    assign tlbVpn2_o = vAddr_i.tlbView.vpn2;
    assign tlbOdd_o  = vAddr_i.tlbView.oddPage;

    always_ff @(posedge clk) begin
        if (!rst) begin
            isKseg0      <= 1'b0;
            isKseg1      <= 1'b0;
            isMapped     <= 1'b0;
            kseg0UnCache <= 1'b0;
        end else if (fetchReq_i) begin
            isKseg0      <= inKseg0;
            isKseg1      <= inKseg1;
            isMapped     <= inMapped;
            kseg0UnCache <= k0Field_i != CACHE_CACHED;
        end
    end

    // Unmapped frame, top three bits dropped
    always_ff @(posedge clk) begin
        if (fetchReq_i) begin
            directTag <= {3'b000, vAddr_i.segView.segOffset[28:12]};
        end
    end

    // ----------------------------------------
    // Cycle 1 combine
    // ----------------------------------------
    assign tag_o     = isMapped ? pfn_i : directTag;
    // kseg1 is uncached whatever K0 says
    assign unCache_o = (isMapped && (c_i != CACHE_CACHED)) ||
                       (isKseg0 && kseg0UnCache) ||
                       isKseg1;
    // Miss or invalid page
    assign tlbExc_o  = isMapped && !(hit_i && v_i);
    // Only a miss takes the refill vector
    assign refill_o  = isMapped && !hit_i;

    // A TLB lookup always lands on a mapped cycle-1 state
    aReqMapped: assert property (
        @(posedge clk) disable iff (!rst)
        tlbReq_o |=> isMapped
    ) else $error("instMmu: TLB request for unmapped address at %0t", $time);

endmodule

//--- instTlb.sv
// Instruction TLB
// Fully associative array of even/odd page pairs with a TLBWI-style
// write port and a registered single-cycle lookup

`timescale 1ns/10ps

module instTlb #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    // Lookup request
    input  logic                               lookReq_i,
    input  logic [mmuPkg::VPN2_W-1:0]          lookVpn2_i,
    input  logic                               lookOdd_i,
    input  logic [mmuPkg::ASID_W-1:0]          lookAsid_i,
    // Indexed write
    input  logic                               tlbWe_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0]     tlbWIndex_i,
    input  logic [mmuPkg::VPN2_W-1:0]          tlbVpn2_i,
    input  logic [mmuPkg::ASID_W-1:0]          tlbAsid_i,
    input  logic                               tlbG_i,
    input  logic [mmuPkg::PFN_W-1:0]           tlbPfn0_i,
    input  logic [2:0]                         tlbC0_i,
    input  logic                               tlbD0_i,
    input  logic                               tlbV0_i,
    input  logic [mmuPkg::PFN_W-1:0]           tlbPfn1_i,
    input  logic [2:0]                         tlbC1_i,
    input  logic                               tlbD1_i,
    input  logic                               tlbV1_i,
    // Lookup result, one cycle after lookReq_i
    output logic                               hit_o,
    output logic [mmuPkg::PFN_W-1:0]           pfn_o,
    output logic [2:0]                         c_o,
    output logic                               v_o
);

    import mmuPkg::*;

    // Entry storage
    logic [VPN2_W-1:0]      vpn2Q [TLB_ENTRIES];
    logic [ASID_W-1:0]      asidQ [TLB_ENTRIES];
    logic [PFN_W-1:0]       pfn0Q [TLB_ENTRIES];
    logic [PFN_W-1:0]       pfn1Q [TLB_ENTRIES];
    logic [2:0]             c0Q   [TLB_ENTRIES];
    logic [2:0]             c1Q   [TLB_ENTRIES];
    // Entry has been written since reset
    logic [TLB_ENTRIES-1:0] liveQ;
    logic [TLB_ENTRIES-1:0] gQ;
    logic [TLB_ENTRIES-1:0] v0Q;
    logic [TLB_ENTRIES-1:0] v1Q;
    // Dirty bits kept for the data side, not checked on fetch
    logic [TLB_ENTRIES-1:0] d0Q;
    logic [TLB_ENTRIES-1:0] d1Q;

    logic [TLB_ENTRIES-1:0] matchVec;
    logic [PFN_W-1:0]       selPfn;
    logic [2:0]             selC;
    logic                   selV;

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            liveQ <= '0;
            gQ    <= '0;
            v0Q   <= '0;
            v1Q   <= '0;
        end else if (tlbWe_i) begin
            liveQ[tlbWIndex_i] <= 1'b1;
            gQ[tlbWIndex_i]    <= tlbG_i;
            v0Q[tlbWIndex_i]   <= tlbV0_i;
            v1Q[tlbWIndex_i]   <= tlbV1_i;
        end
    end

    // Payload fields
    always_ff @(posedge clk) begin
        if (tlbWe_i) begin
            vpn2Q[tlbWIndex_i] <= tlbVpn2_i;
            asidQ[tlbWIndex_i] <= tlbAsid_i;
            pfn0Q[tlbWIndex_i] <= tlbPfn0_i;
            pfn1Q[tlbWIndex_i] <= tlbPfn1_i;
            c0Q[tlbWIndex_i]   <= tlbC0_i;
            c1Q[tlbWIndex_i]   <= tlbC1_i;
            d0Q[tlbWIndex_i]   <= tlbD0_i;
            d1Q[tlbWIndex_i]   <= tlbD1_i;
        end
    end

    // ----------------------------------------
    // Associative match
    // ----------------------------------------
    // Global entries ignore the ASID
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            matchVec[i] = liveQ[i] && (vpn2Q[i] == lookVpn2_i) &&
                          (gQ[i] || (asidQ[i] == lookAsid_i));
        end
    end

    // OR-select, the match vector is at most one-hot
    always_comb begin
        selPfn = '0;
        selC   = '0;
        selV   = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (matchVec[i]) begin
                selPfn = selPfn | (lookOdd_i ? pfn1Q[i] : pfn0Q[i]);
                selC   = selC | (lookOdd_i ? c1Q[i] : c0Q[i]);
                selV   = selV | (lookOdd_i ? v1Q[i] : v0Q[i]);
            end
        end
    end

    // ----------------------------------------
    // Registered result
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            hit_o <= 1'b0;
        end else begin
            hit_o <= lookReq_i && (|matchVec);
        end
    end

    always_ff @(posedge clk) begin
        if (lookReq_i) begin
            pfn_o <= selPfn;
            c_o   <= selC;
            v_o   <= selV;
        end
    end

    // Software must never load overlapping entries
    aSingleMatch: assert property (
        @(posedge clk) disable iff (!rst)
        lookReq_i |-> $onehot0(matchVec)
    ) else $error("instTlb: multiple entries matched at %0t", $time);

endmodule

//--- fetchAlignCheck.sv
// Fetch alignment stage
// Registers the fetch strobe and PC, flags a misaligned PC
// one cycle after the request

`timescale 1ns/10ps

module fetchAlignCheck (
    input  logic         clk,
    input  logic         rst,
    // Fetch request from the PC stage
    input  logic         fetchReq_i,
    input  logic [31:0]  vAddr_i,
    // Stage one view
    output logic         valid_o,
    output mmuPkg::vAddrU vAddr_o,
    output logic         adEL_o
);

    logic misAligned;

    // Instruction words sit on 4-byte boundaries
    assign misAligned = |vAddr_i[1:0];

    // ----------------------------------------
    // Control registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_o <= 1'b0;
            adEL_o  <= 1'b0;
        end else begin
            valid_o <= fetchReq_i;
            // Only a live request can fault
            adEL_o  <= fetchReq_i && misAligned;
        end
    end

    // PC carried forward for the page offset
    always_ff @(posedge clk) begin
        if (fetchReq_i) begin
            vAddr_o <= vAddr_i;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Fault flag never outlives its request
    aAdelHasValid: assert property (
        @(posedge clk) disable iff (!rst)
        adEL_o |-> valid_o
    ) else $error("fetchAlignCheck: adEL_o without valid_o at %0t", $time);

endmodule

//--- mmuPkg.sv
// Instruction MMU shared definitions
// Segment codes, cache attribute, fetch exception codes, field widths
// and the two views of a virtual fetch address

package mmuPkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------
    // Physical frame number, also the page tag
    localparam int PFN_W  = 20;
    // Even/odd page pair number
    localparam int VPN2_W = 19;
    localparam int ASID_W = 8;

    // ----------------------------------------
    // Segment codes, top three address bits
    // ----------------------------------------
    // Direct mapped, cacheability from K0
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    // Direct mapped, never cached
    localparam logic [2:0] SEG_KSEG1 = 3'b101;
    // Anything else goes through the TLB

    // Cache attribute, every other value means uncached
    localparam logic [2:0] CACHE_CACHED = 3'd3;

    // ----------------------------------------
    // Fetch exception codes
    // ----------------------------------------
    // Address error on load or fetch
    localparam logic [4:0] EXC_ADEL = 5'd4;
    // TLB exception on load or fetch
    localparam logic [4:0] EXC_TLBL = 5'd2;

    // ----------------------------------------
    // Virtual address, two decodes of one word
    // ----------------------------------------
    typedef union packed {
        // Segment view for kseg decode
        struct packed {
            logic [2:0]  seg;
            logic [28:0] segOffset;
        } segView;
        // TLB view, page pair plus even/odd select
        struct packed {
            logic [VPN2_W-1:0] vpn2;
            logic              oddPage;
            logic [11:0]       pageOff;
        } tlbView;
    } vAddrU;

endpackage
